// File: hdl/mult_pkg.sv
package mult_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////////////////////

    // Multiplier and multiplicand width
    localparam int OPERAND_WIDTH = 8;

    // Full product, high half joined with low half
    localparam int PRODUCT_WIDTH = 2 * OPERAND_WIDTH;

    // Bit counter must be able to hold OPERAND_WIDTH itself
    localparam int COUNT_WIDTH = $clog2(OPERAND_WIDTH + 1);

    ////////////////////////////////////////////////////////////////////////////
    // Control states
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        // Waiting for start
        STATE_IDLE    = 3'd0,
        // Look at the low bit of the product
        STATE_EXAMINE = 3'd1,
        // Multiplicand into the high half
        STATE_ADD     = 3'd2,
        // Shift after an add
        STATE_SHIFT   = 3'd3,
        // One cycle of done
        STATE_FINISH  = 3'd4
    } ctrl_state_t;

endpackage

// File: hdl/mult_control_unit.sv
`timescale 1ns/1ps

module mult_control_unit (
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  logic lsb,
    output logic load,
    output logic add,
    output logic shift,
    output logic done,
    output logic busy
);

    mult_pkg::ctrl_state_t state_q;
    mult_pkg::ctrl_state_t next_state;

    // Bits still to be shifted out of the low half
    logic [mult_pkg::COUNT_WIDTH-1:0] count_q;
    logic                             count_zero;

    assign count_zero = (count_q == '0);

    ////////////////////////////////////////////////////////////////////////////
    // Control pulses
    ////////////////////////////////////////////////////////////////////////////

    // Start is only honoured from idle, anything else is dropped
    assign load = (state_q == mult_pkg::STATE_IDLE) && start;

    assign add = (state_q == mult_pkg::STATE_ADD);

    // A zero bit shifts straight from EXAMINE, a one bit goes through ADD first
    assign shift = ((state_q == mult_pkg::STATE_EXAMINE) && !count_zero && !lsb)
                || (state_q == mult_pkg::STATE_SHIFT);

    assign done = (state_q == mult_pkg::STATE_FINISH);
    assign busy = (state_q != mult_pkg::STATE_IDLE);

    ////////////////////////////////////////////////////////////////////////////
    // Next state
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        next_state = state_q;
        case (state_q)
            mult_pkg::STATE_IDLE: begin
                if (start) begin
                    next_state = mult_pkg::STATE_EXAMINE;
                end
            end
            mult_pkg::STATE_EXAMINE: begin
                // Counter ran out on the last shift, product is complete
                if (count_zero) begin
                    next_state = mult_pkg::STATE_FINISH;
                end else if (lsb) begin
                    next_state = mult_pkg::STATE_ADD;
                end else begin
                    // Shift happens here, stay and look at the next bit
                    next_state = mult_pkg::STATE_EXAMINE;
                end
            end
            mult_pkg::STATE_ADD: begin
                next_state = mult_pkg::STATE_SHIFT;
            end
            mult_pkg::STATE_SHIFT: begin
                next_state = mult_pkg::STATE_EXAMINE;
            end
            mult_pkg::STATE_FINISH: begin
                next_state = mult_pkg::STATE_IDLE;
            end
            default: begin
                next_state = mult_pkg::STATE_IDLE;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // State and bit counter registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= mult_pkg::STATE_IDLE;
        end else begin
            state_q <= next_state;
        end
    end

    // Down counter, one step per shift
    always_ff @(posedge clk) begin
        if (reset) begin
            count_q <= '0;
        end else if (load) begin
            count_q <= mult_pkg::COUNT_WIDTH'(mult_pkg::OPERAND_WIDTH);
        end else if (shift) begin
            count_q <= count_q - 1'b1;
        end
    end

endmodule

// File: hdl/mult_datapath.sv
`timescale 1ns/1ps

module mult_datapath (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              load,
    input  logic                              add,
    input  logic                              shift,
    input  logic [mult_pkg::OPERAND_WIDTH-1:0] multiplier,
    input  logic [mult_pkg::OPERAND_WIDTH-1:0] multiplicand,
    output logic                              lsb,
    output logic [mult_pkg::PRODUCT_WIDTH-1:0] product
);

    ////////////////////////////////////////////////////////////////////////////
    // Registers
    ////////////////////////////////////////////////////////////////////////////

    // Carry out of the adder above the high half
    logic                              carry_q;

    // Upper half of the running product
    logic [mult_pkg::OPERAND_WIDTH-1:0] high_q;

    // Lower half starts as the multiplier and fills with product bits
    logic [mult_pkg::OPERAND_WIDTH-1:0] low_q;

    // Multiplicand held for the whole multiplication
    logic [mult_pkg::OPERAND_WIDTH-1:0] mcand_q;

    ////////////////////////////////////////////////////////////////////////////
    // Adder
    ////////////////////////////////////////////////////////////////////////////

    // One bit wider to catch the carry out
    logic [mult_pkg::OPERAND_WIDTH:0]   sum;

    // Addend needs no lsb gating since add only comes on a one bit
    assign sum = {1'b0, high_q} + {1'b0, mcand_q};

    ////////////////////////////////////////////////////////////////////////////
    // Shift word
    ////////////////////////////////////////////////////////////////////////////

    // Carry, high and low moved right by one as a single word
    logic [mult_pkg::PRODUCT_WIDTH-1:0] shift_word;

    assign shift_word = {carry_q, high_q, low_q[mult_pkg::OPERAND_WIDTH-1:1]};

    ////////////////////////////////////////////////////////////////////////////
    // Register updates
    ////////////////////////////////////////////////////////////////////////////

    // Carry empties on a shift
    always_ff @(posedge clk) begin
        if (reset) begin
            carry_q <= 1'b0;
        end else if (load) begin
            carry_q <= 1'b0;
        end else if (add) begin
            carry_q <= sum[mult_pkg::OPERAND_WIDTH];
        end else if (shift) begin
            carry_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            high_q <= '0;
        end else if (load) begin
            high_q <= '0;
        end else if (add) begin
            high_q <= sum[mult_pkg::OPERAND_WIDTH-1:0];
        end else if (shift) begin
            high_q <= shift_word[mult_pkg::PRODUCT_WIDTH-1:mult_pkg::OPERAND_WIDTH];
        end
    end

    // Product bits enter from the top as the multiplier bits leave the bottom
    always_ff @(posedge clk) begin
        if (reset) begin
            low_q <= '0;
        end else if (load) begin
            low_q <= multiplier;
        end else if (shift) begin
            low_q <= shift_word[mult_pkg::OPERAND_WIDTH-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            mcand_q <= multiplicand;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Outputs
    ////////////////////////////////////////////////////////////////////////////

    // Bit under examination by the control unit
    assign lsb = low_q[0];

    // Complete once all operand bits are shifted through
    assign product = {high_q, low_q};

endmodule

// File: hdl/shift_add_multiplier.sv
`timescale 1ns/1ps

module shift_add_multiplier (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              start,
    input  logic [mult_pkg::OPERAND_WIDTH-1:0] multiplier,
    input  logic [mult_pkg::OPERAND_WIDTH-1:0] multiplicand,
    output logic [mult_pkg::PRODUCT_WIDTH-1:0] product,
    output logic                              done,
    output logic                              busy
);

    ////////////////////////////////////////////////////////////////////////////
    // Control to datapath
    ////////////////////////////////////////////////////////////////////////////

    logic load;
    logic add;
    logic shift;

    // Datapath to control, low bit of the product
    logic lsb;

    ////////////////////////////////////////////////////////////////////////////
    // Sequencer
    ////////////////////////////////////////////////////////////////////////////

    mult_control_unit control_unit_inst (
        .clk   (clk),
        .reset (reset),
        .start (start),
        .lsb   (lsb),
        .load  (load),
        .add   (add),
        .shift (shift),
        .done  (done),
        .busy  (busy)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Product registers and adder
    ////////////////////////////////////////////////////////////////////////////

    mult_datapath datapath_inst (
        .clk          (clk),
        .reset        (reset),
        .load         (load),
        .add          (add),
        .shift        (shift),
        .multiplier   (multiplier),
        .multiplicand (multiplicand),
        .lsb          (lsb),
        .product      (product)
    );

endmodule

// File: testbench/mult_checker.sv
`timescale 1ns/1ps

module mult_checker (
    input logic                               clk,
    input logic                               reset,
    input logic                               start,
    input logic [mult_pkg::OPERAND_WIDTH-1:0] multiplier,
    input logic [mult_pkg::OPERAND_WIDTH-1:0] multiplicand,
    input logic [mult_pkg::PRODUCT_WIDTH-1:0] product,
    input logic                               done,
    input logic                               busy
);

    int unsigned product_errors;
    int unsigned latency_errors;
    int unsigned protocol_errors;
    int unsigned products_checked;

    int unsigned cycle;
    int unsigned accept_cycle;
    int unsigned expected_latency;
    int unsigned actual_latency;
    logic        pending;
    logic        holding;

    logic [mult_pkg::PRODUCT_WIDTH-1:0] expected_product;
    logic [mult_pkg::PRODUCT_WIDTH-1:0] held_product;

    initial begin
        product_errors   = 0;
        latency_errors   = 0;
        protocol_errors  = 0;
        products_checked = 0;
        cycle            = 0;
        accept_cycle     = 0;
        expected_latency = 0;
        actual_latency   = 0;
        pending          = 1'b0;
        holding          = 1'b0;
        expected_product = '0;
        held_product     = '0;
    end

    function automatic int unsigned count_ones(input logic [mult_pkg::OPERAND_WIDTH-1:0] value);
        int unsigned ones;
        int          i;
        ones = 0;
        for (i = 0; i < mult_pkg::OPERAND_WIDTH; i++) begin
            ones += value[i];
        end
        return ones;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Sampling at the rising edge, values are those of the ending cycle
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (reset) begin
            // Reset state counts as a held product of zero
            pending      = 1'b0;
            holding      = 1'b1;
            held_product = '0;
        end else begin
            if (busy !== pending) begin
                protocol_errors++;
                $display("CHECK FAILED busy expected 0x%h actual 0x%h at %0t",
                         pending, busy, $time);
            end
            if (holding && product !== held_product) begin
                product_errors++;
                $display("CHECK FAILED product expected 0x%h actual 0x%h at %0t (hold)",
                         held_product, product, $time);
            end
            if (done === 1'b1) begin
                if (!pending) begin
                    protocol_errors++;
                    $display("done was raised with no multiplication in progress at %0t",
                             $time);
                end else begin
                    // done rose one edge before this sample
                    actual_latency = cycle - accept_cycle - 1;
                    if (actual_latency != expected_latency) begin
                        latency_errors++;
                        $display("CHECK FAILED done latency expected 0x%h actual 0x%h at %0t",
                                 expected_latency, actual_latency, $time);
                    end
                    if (product !== expected_product) begin
                        product_errors++;
                        $display("CHECK FAILED product expected 0x%h actual 0x%h at %0t",
                                 expected_product, product, $time);
                    end
                    products_checked++;
                    pending      = 1'b0;
                    holding      = 1'b1;
                    held_product = product;
                end
            end else if (pending && (cycle - accept_cycle - 1) == expected_latency) begin
                latency_errors++;
                $display("done did not rise %0d cycles after the accepted start at %0t",
                         expected_latency, $time);
            end
            // Only a start seen from idle is taken
            if (start === 1'b1 && busy === 1'b0) begin
                pending          = 1'b1;
                holding          = 1'b0;
                accept_cycle     = cycle;
                expected_product = mult_pkg::PRODUCT_WIDTH'(multiplier)
                                 * mult_pkg::PRODUCT_WIDTH'(multiplicand);
                // One examine per bit, add and shift for each set bit, a final examine
                expected_latency = mult_pkg::OPERAND_WIDTH + 2 * count_ones(multiplier) + 1;
            end
        end
    end

endmodule

// File: testbench/mult_props.sv
`timescale 1ns/1ps

module mult_props (
    input logic clk,
    input logic reset,
    input logic load,
    input logic add,
    input logic shift,
    input logic done
);

    int unsigned failures = 0;

    done_single_cycle: assert property (@(posedge clk) disable iff (reset) done |=> !done)
        else begin
            failures++;
            $error("done stayed high for a second cycle");
        end

    pulses_exclusive: assert property (@(posedge clk) disable iff (reset)
        $onehot0({load, add, shift}))
        else begin
            failures++;
            $error("more than one of load, add and shift is high");
        end

    add_then_shift: assert property (@(posedge clk) disable iff (reset) add |=> shift)
        else begin
            failures++;
            $error("add was not followed by shift");
        end

    done_low_in_reset: assert property (@(posedge clk) reset |=> !done)
        else begin
            failures++;
            $error("done was high right after a reset edge");
        end

endmodule

bind mult_control_unit mult_props props_inst (
    .clk   (clk),
    .reset (reset),
    .load  (load),
    .add   (add),
    .shift (shift),
    .done  (done)
);

// File: testbench/tb_shift_add_multiplier.sv
`timescale 1ns/1ps

module tb_shift_add_multiplier;

    localparam int DONE_TIMEOUT   = 40;
    localparam int RANDOM_RUNS    = 300;
    localparam int INTRUSION_RUNS = 24;

    logic                               clk;
    logic                               reset;
    logic                               start;
    logic [mult_pkg::OPERAND_WIDTH-1:0] multiplier;
    logic [mult_pkg::OPERAND_WIDTH-1:0] multiplicand;
    logic [mult_pkg::PRODUCT_WIDTH-1:0] product;
    logic                               done;
    logic                               busy;

    integer      seed;
    int unsigned timeout_errors;
    int unsigned started;

    shift_add_multiplier shift_add_multiplier_inst (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .multiplier   (multiplier),
        .multiplicand (multiplicand),
        .product      (product),
        .done         (done),
        .busy         (busy)
    );

    mult_checker mult_checker_inst (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .multiplier   (multiplier),
        .multiplicand (multiplicand),
        .product      (product),
        .done         (done),
        .busy         (busy)
    );

    initial begin
        clk = 1'b0;
    end

    always #10 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus helpers driving after a falling edge
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [mult_pkg::OPERAND_WIDTH-1:0] random_operand();
        logic [31:0] raw;
        raw = $random(seed);
        return raw[mult_pkg::OPERAND_WIDTH-1:0];
    endfunction

    function automatic int random_below(input int limit);
        logic [31:0] raw;
        raw = $random(seed);
        return int'(raw % limit);
    endfunction

    // One cycle of start then scrambled operands
    task automatic pulse_start(input logic [mult_pkg::OPERAND_WIDTH-1:0] a,
                               input logic [mult_pkg::OPERAND_WIDTH-1:0] b);
        start        = 1'b1;
        multiplier   = a;
        multiplicand = b;
        @(negedge clk);
        start        = 1'b0;
        multiplier   = random_operand();
        multiplicand = random_operand();
    endtask

    task automatic wait_for_done();
        int cycles;
        cycles = 0;
        while (done !== 1'b1 && cycles < DONE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (done !== 1'b1) begin
            timeout_errors++;
            $display("done never arrived within %0d cycles at %0t", DONE_TIMEOUT, $time);
        end
    endtask

    task automatic multiply(input logic [mult_pkg::OPERAND_WIDTH-1:0] a,
                            input logic [mult_pkg::OPERAND_WIDTH-1:0] b);
        @(negedge clk);
        pulse_start(a, b);
        started++;
        wait_for_done();
    endtask

    // Second start lands while busy and must be dropped
    task automatic multiply_with_intrusion(input logic [mult_pkg::OPERAND_WIDTH-1:0] a,
                                           input logic [mult_pkg::OPERAND_WIDTH-1:0] b,
                                           input int gap);
        @(negedge clk);
        pulse_start(a, b);
        started++;
        repeat (gap - 1) @(negedge clk);
        pulse_start(~a, b + 8'd1);
        wait_for_done();
    endtask

    task automatic idle_gap(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            multiplier   = random_operand();
            multiplicand = random_operand();
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int                               i;
        int unsigned                      total_errors;
        logic [mult_pkg::OPERAND_WIDTH-1:0] single_bit;

        seed           = 56326;
        reset          = 1'b1;
        start          = 1'b0;
        multiplier     = '0;
        multiplicand   = '0;
        timeout_errors = 0;
        started        = 0;

        repeat (8) @(negedge clk);
        reset = 1'b0;
        // Quiet period with the product held at zero
        idle_gap(5);

        // Corner operands
        multiply(8'h00, 8'h00);
        multiply(8'h00, 8'hff);
        multiply(8'hff, 8'h00);
        multiply(8'hff, 8'hff);
        for (i = 0; i < mult_pkg::OPERAND_WIDTH; i++) begin
            single_bit    = '0;
            single_bit[i] = 1'b1;
            multiply(single_bit, random_operand());
            multiply(random_operand(), single_bit);
        end

        for (i = 0; i < RANDOM_RUNS; i++) begin
            multiply(random_operand(), random_operand());
            idle_gap(random_below(8));
        end

        for (i = 0; i < INTRUSION_RUNS; i++) begin
            multiply_with_intrusion(random_operand(), random_operand(), 1 + random_below(7));
            idle_gap(random_below(4));
        end

        idle_gap(4);

        total_errors = mult_checker_inst.product_errors
                     + mult_checker_inst.latency_errors
                     + mult_checker_inst.protocol_errors
                     + shift_add_multiplier_inst.control_unit_inst.props_inst.failures
                     + timeout_errors;
        $write("Errors: product %0d, latency %0d, protocol %0d, ",
               mult_checker_inst.product_errors,
               mult_checker_inst.latency_errors,
               mult_checker_inst.protocol_errors);
        $display("assertion %0d, timeout %0d, checked %0d of %0d",
                 shift_add_multiplier_inst.control_unit_inst.props_inst.failures,
                 timeout_errors,
                 mult_checker_inst.products_checked,
                 started);
        if (total_errors == 0 && mult_checker_inst.products_checked == started) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: filelist.f
hdl/mult_pkg.sv
hdl/mult_control_unit.sv
hdl/mult_datapath.sv
hdl/shift_add_multiplier.sv
testbench/mult_checker.sv
testbench/mult_props.sv
testbench/tb_shift_add_multiplier.sv

// File: Bender.yml
package:
  name: shift_add_multiplier

sources:
  - hdl/mult_pkg.sv
  - hdl/mult_control_unit.sv
  - hdl/mult_datapath.sv
  - hdl/shift_add_multiplier.sv
  - target: test
    files:
      - testbench/mult_checker.sv
      - testbench/mult_props.sv
      - testbench/tb_shift_add_multiplier.sv
